/* common/nw_join_pkg.sv */
//////////////////////////////
// Narrow/wide join package
// Widths, vector types and channel structs shared by the join
//////////////////////////////

package nw_join_pkg;

  //////////////////////////////
  // Widths and limits
  //////////////////////////////

  localparam int unsigned AddrWidth       = 32;
  localparam int unsigned NarrowDataWidth = 32;
  localparam int unsigned WideDataWidth   = 128;
  localparam int unsigned ReqIdWidth      = 3;
  // One extra bit on top of the requester ID tells the source port
  localparam int unsigned JoinIdWidth     = ReqIdWidth + 1;
  localparam int unsigned LaneCount       = WideDataWidth / NarrowDataWidth;
  localparam int unsigned LaneIdxWidth    = $clog2(LaneCount);
  localparam int unsigned NarrowMaxTxns   = 8;

  // Byte offset bits inside one narrow word, the lane index sits above them
  localparam int unsigned NarrowOffWidth   = $clog2(NarrowDataWidth / 8);
  localparam int unsigned LaneFifoPtrWidth = $clog2(NarrowMaxTxns);

  //////////////////////////////
  // Vector types
  //////////////////////////////

  typedef logic [AddrWidth-1:0]         addr_t;
  typedef logic [NarrowDataWidth-1:0]   narrow_data_t;
  typedef logic [WideDataWidth-1:0]     wide_data_t;
  typedef logic [NarrowDataWidth/8-1:0] narrow_strb_t;
  typedef logic [WideDataWidth/8-1:0]   wide_strb_t;
  typedef logic [ReqIdWidth-1:0]        req_id_t;
  typedef logic [JoinIdWidth-1:0]       join_id_t;
  typedef logic [LaneIdxWidth-1:0]      lane_idx_t;

  //////////////////////////////
  // Channel payloads
  //////////////////////////////

  typedef struct packed {
    logic         we;
    addr_t        addr;
    req_id_t      id;
    narrow_data_t data;
    narrow_strb_t strb;
  } narrow_req_t;

  typedef struct packed {
    req_id_t      id;
    narrow_data_t data;
    logic         err;
  } narrow_rsp_t;

  typedef struct packed {
    logic       we;
    addr_t      addr;
    req_id_t    id;
    wide_data_t data;
    wide_strb_t strb;
  } wide_req_t;

  typedef struct packed {
    req_id_t    id;
    wide_data_t data;
    logic       err;
  } wide_rsp_t;

  typedef struct packed {
    logic       we;
    addr_t      addr;
    join_id_t   id;
    wide_data_t data;
    wide_strb_t strb;
  } join_req_t;

  typedef struct packed {
    join_id_t   id;
    wide_data_t data;
    logic       err;
  } join_rsp_t;

  // Value of the source bit in the extended ID, also the mux grant
  typedef enum logic {
    SRC_WIDE   = 1'b0,
    SRC_NARROW = 1'b1
  } src_sel_e;

endpackage

/* narrow_upsizer/narrow_upsizer.sv */
//////////////////////////////
// Narrow upsizer
// Moves 32-bit requests into the 128-bit lane picked by the address
// and returns the matching word of each wide response
//////////////////////////////

module narrow_upsizer import nw_join_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  // Narrow requester side
  input  narrow_req_t slv_req_i,
  input  logic        slv_req_valid_i,
  output logic        slv_req_ready_o,
  output narrow_rsp_t slv_rsp_o,
  output logic        slv_rsp_valid_o,
  input  logic        slv_rsp_ready_i,
  // Wide side toward the mux
  output wide_req_t   mst_req_o,
  output logic        mst_req_valid_o,
  input  logic        mst_req_ready_i,
  input  wide_rsp_t   mst_rsp_i,
  input  logic        mst_rsp_valid_i,
  output logic        mst_rsp_ready_o
);

  lane_idx_t req_lane;
  lane_idx_t head_lane;
  logic      push;
  logic      pop;
  logic      fifo_full;
  logic      fifo_empty;

  // Lane FIFO storage and pointers
  lane_idx_t                   lane_fifo_q [NarrowMaxTxns];
  logic [LaneFifoPtrWidth-1:0] wr_ptr_q;
  logic [LaneFifoPtrWidth-1:0] rd_ptr_q;
  logic [LaneFifoPtrWidth:0]   fifo_cnt_q;

  //////////////////////////////
  // Request path
  //////////////////////////////

  assign req_lane = slv_req_i.addr[NarrowOffWidth +: LaneIdxWidth];

  // The narrow word is copied into every lane, so only the strobe has to move
  always_comb begin
    mst_req_o.we   = slv_req_i.we;
    mst_req_o.addr = slv_req_i.addr;
    mst_req_o.id   = slv_req_i.id;
    mst_req_o.data = {LaneCount{slv_req_i.data}};
    mst_req_o.strb = wide_strb_t'(slv_req_i.strb) << (req_lane * (NarrowDataWidth / 8));
  end

  // Hold off new requests once every FIFO slot is taken
  assign mst_req_valid_o = slv_req_valid_i && !fifo_full;
  assign slv_req_ready_o = mst_req_ready_i && !fifo_full;

  assign push = slv_req_valid_i && slv_req_ready_o;

  //////////////////////////////
  // Response path
  //////////////////////////////

  assign head_lane = lane_fifo_q[rd_ptr_q];

  always_comb begin
    slv_rsp_o.id   = mst_rsp_i.id;
    slv_rsp_o.data = mst_rsp_i.data[head_lane * NarrowDataWidth +: NarrowDataWidth];
    slv_rsp_o.err  = mst_rsp_i.err;
  end

  assign slv_rsp_valid_o = mst_rsp_valid_i;
  assign mst_rsp_ready_o = slv_rsp_ready_i;

  assign pop = mst_rsp_valid_i && slv_rsp_ready_i;

  //////////////////////////////
  // Lane FIFO
  //////////////////////////////

  assign fifo_full  = (fifo_cnt_q == (LaneFifoPtrWidth + 1)'(NarrowMaxTxns));
  assign fifo_empty = (fifo_cnt_q == '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // A push and a pop in the same cycle leave the fill level alone
      case ({push, pop})
        2'b10:   fifo_cnt_q <= fifo_cnt_q + 1'b1;
        2'b01:   fifo_cnt_q <= fifo_cnt_q - 1'b1;
        default: fifo_cnt_q <= fifo_cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      lane_fifo_q[wr_ptr_q] <= req_lane;
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Every wide response must belong to a narrow request accepted earlier
  a_no_rsp_when_empty : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mst_rsp_valid_i |-> !fifo_empty
  );

  // A push into a full FIFO would carry the fill level past its depth
  a_no_push_when_full : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    fifo_cnt_q <= (LaneFifoPtrWidth + 1)'(NarrowMaxTxns)
  );

endmodule

/* join_mux/join_mux.sv */
//////////////////////////////
// Join mux
// Round-robin arbiter for two wide requesters with a registered output,
// source bit ID extension and response routing by that bit
//////////////////////////////

module join_mux import nw_join_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // Requester side, index 0 is the wide port and index 1 the narrow port
  input  wide_req_t [1:0] slv_reqs_i,
  input  logic      [1:0] slv_req_valids_i,
  output logic      [1:0] slv_req_readys_o,
  output wide_rsp_t [1:0] slv_rsps_o,
  output logic      [1:0] slv_rsp_valids_o,
  input  logic      [1:0] slv_rsp_readys_i,
  // Memory side
  output join_req_t       mst_req_o,
  output logic            mst_req_valid_o,
  input  logic            mst_req_ready_i,
  input  join_rsp_t       mst_rsp_i,
  input  logic            mst_rsp_valid_i,
  output logic            mst_rsp_ready_o
);

  src_sel_e  prio_q;
  src_sel_e  grant;
  src_sel_e  rsp_src;
  logic      can_load;
  logic      load;
  logic      req_valid_q;
  join_req_t req_q;

  //////////////////////////////
  // Arbitration
  //////////////////////////////

  // The source holding priority wins if it asks, otherwise the other one
  assign grant = slv_req_valids_i[prio_q] ? prio_q : src_sel_e'(~prio_q);

  // The output register takes a new request when empty or draining this cycle
  assign can_load = !req_valid_q || mst_req_ready_i;
  assign load     = can_load && (|slv_req_valids_i);

  always_comb begin
    slv_req_readys_o        = '0;
    slv_req_readys_o[grant] = can_load;
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_valid_q <= 1'b0;
      prio_q      <= SRC_WIDE;
    end else begin
      if (load) begin
        req_valid_q <= 1'b1;
        // Hand priority to the source that just lost
        prio_q      <= src_sel_e'(~grant);
      end else if (mst_req_ready_i) begin
        req_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      req_q.we   <= slv_reqs_i[grant].we;
      req_q.addr <= slv_reqs_i[grant].addr;
      // Source bit goes on top of the requester ID
      req_q.id   <= {grant, slv_reqs_i[grant].id};
      req_q.data <= slv_reqs_i[grant].data;
      req_q.strb <= slv_reqs_i[grant].strb;
    end
  end

  assign mst_req_o       = req_q;
  assign mst_req_valid_o = req_valid_q;

  //////////////////////////////
  // Response routing
  //////////////////////////////

  assign rsp_src = src_sel_e'(mst_rsp_i.id[JoinIdWidth-1]);

  // Both ports see the same payload, only the valid is steered
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      slv_rsps_o[i].id      = mst_rsp_i.id[ReqIdWidth-1:0];
      slv_rsps_o[i].data    = mst_rsp_i.data;
      slv_rsps_o[i].err     = mst_rsp_i.err;
      slv_rsp_valids_o[i]   = mst_rsp_valid_i && (int'(rsp_src) == i);
    end
  end

  assign mst_rsp_ready_o = slv_rsp_readys_i[rsp_src];

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // A stalled request must not change until the memory takes it
  a_req_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mst_req_valid_o && !mst_req_ready_i |=> mst_req_valid_o && $stable(mst_req_o)
  );

endmodule

/* source/nw_join_top.sv */
//////////////////////////////
// Narrow/wide join top
// Upsizes the narrow port and muxes it with the wide port
//////////////////////////////

module nw_join_top import nw_join_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  // Narrow requester port
  input  narrow_req_t narrow_req_i,
  input  logic        narrow_req_valid_i,
  output logic        narrow_req_ready_o,
  output narrow_rsp_t narrow_rsp_o,
  output logic        narrow_rsp_valid_o,
  input  logic        narrow_rsp_ready_i,
  // Wide requester port
  input  wide_req_t   wide_req_i,
  input  logic        wide_req_valid_i,
  output logic        wide_req_ready_o,
  output wide_rsp_t   wide_rsp_o,
  output logic        wide_rsp_valid_o,
  input  logic        wide_rsp_ready_i,
  // Joined memory port
  output join_req_t   join_req_o,
  output logic        join_req_valid_o,
  input  logic        join_req_ready_i,
  input  join_rsp_t   join_rsp_i,
  input  logic        join_rsp_valid_i,
  output logic        join_rsp_ready_o
);

  wide_req_t       upsized_req;
  logic            upsized_req_valid;
  logic            upsized_rsp_ready;
  wide_rsp_t [1:0] mux_rsps;
  logic      [1:0] mux_req_readys;
  logic      [1:0] mux_rsp_valids;

  narrow_upsizer u_narrow_upsizer (
    .clk_i           ( clk_i                      ),
    .rst_n_i         ( rst_n_i                    ),
    .slv_req_i       ( narrow_req_i               ),
    .slv_req_valid_i ( narrow_req_valid_i         ),
    .slv_req_ready_o ( narrow_req_ready_o         ),
    .slv_rsp_o       ( narrow_rsp_o               ),
    .slv_rsp_valid_o ( narrow_rsp_valid_o         ),
    .slv_rsp_ready_i ( narrow_rsp_ready_i         ),
    .mst_req_o       ( upsized_req                ),
    .mst_req_valid_o ( upsized_req_valid          ),
    .mst_req_ready_i ( mux_req_readys[SRC_NARROW] ),
    .mst_rsp_i       ( mux_rsps[SRC_NARROW]       ),
    .mst_rsp_valid_i ( mux_rsp_valids[SRC_NARROW] ),
    .mst_rsp_ready_o ( upsized_rsp_ready          )
  );

  // Port 0 carries the wide requester, port 1 the upsized narrow one
  join_mux u_join_mux (
    .clk_i            ( clk_i                                  ),
    .rst_n_i          ( rst_n_i                                ),
    .slv_reqs_i       ( {upsized_req, wide_req_i}              ),
    .slv_req_valids_i ( {upsized_req_valid, wide_req_valid_i}  ),
    .slv_req_readys_o ( mux_req_readys                         ),
    .slv_rsps_o       ( mux_rsps                               ),
    .slv_rsp_valids_o ( mux_rsp_valids                         ),
    .slv_rsp_readys_i ( {upsized_rsp_ready, wide_rsp_ready_i}  ),
    .mst_req_o        ( join_req_o                             ),
    .mst_req_valid_o  ( join_req_valid_o                       ),
    .mst_req_ready_i  ( join_req_ready_i                       ),
    .mst_rsp_i        ( join_rsp_i                             ),
    .mst_rsp_valid_i  ( join_rsp_valid_i                       ),
    .mst_rsp_ready_o  ( join_rsp_ready_o                       )
  );

  assign wide_req_ready_o = mux_req_readys[SRC_WIDE];
  assign wide_rsp_o       = mux_rsps[SRC_WIDE];
  assign wide_rsp_valid_o = mux_rsp_valids[SRC_WIDE];

endmodule

/* verif/tb_clk_gen.sv */
//////////////////////////////
// Testbench clock and reset
// 40 ns clock, reset held low for the first 16 cycles
//////////////////////////////

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam time         HalfPeriod  = 20ns;
  localparam int unsigned ResetCycles = 16;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Release lands just after an edge so the DUT sees it on the next one
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1ns;
    rst_n_o = 1'b1;
  end

endmodule

/* verif/tb_mem_model.sv */
//////////////////////////////
// Memory model for the joined port
// Sparse line memory that answers in request order after a random
// delay, with random request ready and a source bit check
//////////////////////////////

module tb_mem_model import nw_join_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      hold_rsp_i,
  input  join_req_t req_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  output join_rsp_t rsp_o,
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output logic      src_err_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned LineOffWidth = $clog2(WideDataWidth / 8);
  localparam int unsigned MaxDelay     = 6;

  wide_data_t mem_q [addr_t];
  join_rsp_t  rsp_fifo [$];
  longint     due_fifo [$];
  longint     cycle;

  // Unwritten lines read back a pattern built from the line address
  function automatic wide_data_t fill_line(addr_t line);
    return {LaneCount{line ^ 32'h5ac3_9e17}};
  endfunction

  // Writes return zero data, reads return the whole line
  function automatic wide_data_t serve(join_req_t req);
    addr_t      line;
    wide_data_t cur;
    line = req.addr >> LineOffWidth;
    cur  = mem_q.exists(line) ? mem_q[line] : fill_line(line);
    if (!req.we) begin
      return cur;
    end
    for (int b = 0; b < WideDataWidth / 8; b++) begin
      if (req.strb[b]) begin
        cur[8*b +: 8] = req.data[8*b +: 8];
      end
    end
    mem_q[line] = cur;
    return '0;
  endfunction

  initial begin
    logic      req_fire;
    logic      rsp_fire;
    logic      hold;
    join_req_t req;
    join_rsp_t rsp;
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_o       = '0;
    src_err_o   = 1'b0;
    cycle       = 0;
    forever begin
      // Handshakes are sampled mid cycle, outputs change just after the edge
      @(negedge clk_i);
      req_fire = rst_n_i && req_valid_i && req_ready_o;
      rsp_fire = rst_n_i && rsp_valid_o && rsp_ready_i;
      hold     = hold_rsp_i;
      req      = req_i;
      @(posedge clk_i);
      #2ns;
      cycle++;
      if (!rst_n_i) begin
        req_ready_o = 1'b0;
        rsp_valid_o = 1'b0;
        rsp_fifo.delete();
        due_fifo.delete();
      end else begin
        if (req_fire) begin
          // The requesters give narrow requests odd IDs and wide ones even IDs
          if (req.id[JoinIdWidth-1] != req.id[0]) begin
            src_err_o = 1'b1;
          end
          rsp.id   = req.id;
          // The upper half of the address space is unmapped and answers with an error
          rsp.err  = req.addr[AddrWidth-1];
          rsp.data = rsp.err ? '0 : serve(req);
          rsp_fifo.push_back(rsp);
          due_fifo.push_back(cycle + $urandom_range(MaxDelay));
        end
        if (rsp_fire) begin
          rsp_valid_o = 1'b0;
        end
        if (!rsp_valid_o && !hold && rsp_fifo.size() > 0 && due_fifo[0] <= cycle) begin
          rsp_o       = rsp_fifo.pop_front();
          void'(due_fifo.pop_front());
          rsp_valid_o = 1'b1;
        end
        req_ready_o = ($urandom_range(3) != 0);
      end
    end
  end

endmodule

/* verif/tb_nw_join.sv */
//////////////////////////////
// Narrow/wide join testbench
// Directed and random traffic on both requester ports,
// checked against a reference line memory
//////////////////////////////

module tb_nw_join import nw_join_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned LineOffWidth = $clog2(WideDataWidth / 8);
  localparam int unsigned Timeout      = 200;
  localparam int unsigned RandTxns     = 300;
  localparam int unsigned StallCycles  = 20;

  logic        clk;
  logic        rst_n;
  narrow_req_t narrow_req;
  logic        narrow_req_valid;
  logic        narrow_req_ready;
  narrow_rsp_t narrow_rsp;
  logic        narrow_rsp_valid;
  logic        narrow_rsp_ready;
  wide_req_t   wide_req;
  logic        wide_req_valid;
  logic        wide_req_ready;
  wide_rsp_t   wide_rsp;
  logic        wide_rsp_valid;
  logic        wide_rsp_ready;
  join_req_t   join_req;
  logic        join_req_valid;
  logic        join_req_ready;
  join_rsp_t   join_rsp;
  logic        join_rsp_valid;
  logic        join_rsp_ready;
  logic        hold_rsp;
  logic        src_err;
  logic        rand_rsp_ready;

  wide_data_t  ref_mem [addr_t];
  narrow_rsp_t exp_narrow [$];
  wide_rsp_t   exp_wide [$];

  tb_clk_gen u_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  nw_join_top u_dut (
    .clk_i              ( clk              ),
    .rst_n_i            ( rst_n            ),
    .narrow_req_i       ( narrow_req       ),
    .narrow_req_valid_i ( narrow_req_valid ),
    .narrow_req_ready_o ( narrow_req_ready ),
    .narrow_rsp_o       ( narrow_rsp       ),
    .narrow_rsp_valid_o ( narrow_rsp_valid ),
    .narrow_rsp_ready_i ( narrow_rsp_ready ),
    .wide_req_i         ( wide_req         ),
    .wide_req_valid_i   ( wide_req_valid   ),
    .wide_req_ready_o   ( wide_req_ready   ),
    .wide_rsp_o         ( wide_rsp         ),
    .wide_rsp_valid_o   ( wide_rsp_valid   ),
    .wide_rsp_ready_i   ( wide_rsp_ready   ),
    .join_req_o         ( join_req         ),
    .join_req_valid_o   ( join_req_valid   ),
    .join_req_ready_i   ( join_req_ready   ),
    .join_rsp_i         ( join_rsp         ),
    .join_rsp_valid_i   ( join_rsp_valid   ),
    .join_rsp_ready_o   ( join_rsp_ready   )
  );

  tb_mem_model u_mem_model (
    .clk_i       ( clk            ),
    .rst_n_i     ( rst_n          ),
    .hold_rsp_i  ( hold_rsp       ),
    .req_i       ( join_req       ),
    .req_valid_i ( join_req_valid ),
    .req_ready_o ( join_req_ready ),
    .rsp_o       ( join_rsp       ),
    .rsp_valid_o ( join_rsp_valid ),
    .rsp_ready_i ( join_rsp_ready ),
    .src_err_o   ( src_err        )
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped after an error");
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic wide_data_t fill_line(addr_t line);
    return {LaneCount{line ^ 32'h5ac3_9e17}};
  endfunction

  // Returns the response line: zero for a write, the stored line for a read
  function automatic wide_data_t ref_access(logic we, addr_t addr, wide_data_t data,
                                            wide_strb_t strb);
    addr_t      line;
    wide_data_t cur;
    line = addr >> LineOffWidth;
    cur  = ref_mem.exists(line) ? ref_mem[line] : fill_line(line);
    if (!we) begin
      return cur;
    end
    for (int b = 0; b < WideDataWidth / 8; b++) begin
      if (strb[b]) begin
        cur[8*b +: 8] = data[8*b +: 8];
      end
    end
    ref_mem[line] = cur;
    return '0;
  endfunction

  // A narrow access lands in lane addr[3:2] with its data in every lane
  function automatic narrow_data_t ref_narrow(narrow_req_t req);
    int unsigned lane;
    wide_strb_t  strb;
    wide_data_t  line_data;
    lane = req.addr[3:2];
    strb = '0;
    for (int b = 0; b < 4; b++) begin
      strb[lane*4 + b] = req.strb[b];
    end
    line_data = ref_access(req.we, req.addr, {LaneCount{req.data}}, strb);
    return line_data[lane*32 +: 32];
  endfunction

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  task automatic send(input src_sel_e src, input narrow_req_t n_req, input wide_req_t w_req);
    logic        fire;
    int unsigned waited;
    fire   = 1'b0;
    waited = 0;
    if (src == SRC_NARROW) begin
      narrow_req       = n_req;
      narrow_req_valid = 1'b1;
    end else begin
      wide_req       = w_req;
      wide_req_valid = 1'b1;
    end
    while (!fire) begin
      if (waited == Timeout) begin
        fail_run("Timeout waiting for a requester port to accept a request");
      end
      @(negedge clk);
      fire = (src == SRC_NARROW) ? narrow_req_ready : wide_req_ready;
      @(posedge clk);
      #2ns;
      waited++;
    end
    if (src == SRC_NARROW) begin
      narrow_req_valid = 1'b0;
    end else begin
      wide_req_valid = 1'b0;
    end
  endtask

  task automatic drain();
    int unsigned waited;
    waited = 0;
    while (exp_narrow.size() != 0 || exp_wide.size() != 0) begin
      if (waited == Timeout) begin
        fail_run("Timeout waiting for outstanding responses");
      end
      @(posedge clk);
      #2ns;
      waited++;
    end
  endtask

  // Now and then a request goes to the unmapped upper half of the address space
  function automatic narrow_req_t rand_narrow();
    narrow_req_t req;
    req.we   = $urandom_range(1);
    req.addr = 32'h400 + ($urandom_range(63) << 2);
    req.id   = {2'($urandom_range(3)), 1'b1};
    req.data = $urandom;
    req.strb = 4'($urandom_range(15));
    if ($urandom_range(15) == 0) begin
      req.addr[AddrWidth-1] = 1'b1;
    end
    return req;
  endfunction

  function automatic wide_req_t rand_wide();
    wide_req_t req;
    req.we   = $urandom_range(1);
    req.addr = 32'h400 + ($urandom_range(15) << 4);
    req.id   = {2'($urandom_range(3)), 1'b0};
    req.data = {$urandom, $urandom, $urandom, $urandom};
    req.strb = 16'($urandom);
    if ($urandom_range(15) == 0) begin
      req.addr[AddrWidth-1] = 1'b1;
    end
    return req;
  endfunction

  //////////////////////////////
  // Comparison
  //////////////////////////////

  initial begin : compare_proc
    narrow_rsp_t exp_n;
    wide_rsp_t   exp_w;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        // Unmapped accesses answer with an error and zero data and leave memory alone
        if (narrow_req_valid && narrow_req_ready) begin
          exp_n.id   = narrow_req.id;
          exp_n.err  = narrow_req.addr[AddrWidth-1];
          exp_n.data = exp_n.err ? '0 : ref_narrow(narrow_req);
          exp_narrow.push_back(exp_n);
        end
        if (wide_req_valid && wide_req_ready) begin
          exp_w.id   = wide_req.id;
          exp_w.err  = wide_req.addr[AddrWidth-1];
          exp_w.data = exp_w.err ? '0 :
                       ref_access(wide_req.we, wide_req.addr, wide_req.data, wide_req.strb);
          exp_wide.push_back(exp_w);
        end
        if (narrow_rsp_valid && narrow_rsp_ready) begin
          assert (exp_narrow.size() > 0) else fail_run("Narrow response without a request");
          exp_n = exp_narrow.pop_front();
          assert (narrow_rsp == exp_n) else fail_run($sformatf(
            "ERR @ %0t: narrow rsp id %0d data %h err %b, expected id %0d data %h err %b",
            $time, narrow_rsp.id, narrow_rsp.data, narrow_rsp.err,
            exp_n.id, exp_n.data, exp_n.err));
        end
        if (wide_rsp_valid && wide_rsp_ready) begin
          assert (exp_wide.size() > 0) else fail_run("Wide response without a request");
          exp_w = exp_wide.pop_front();
          assert (wide_rsp == exp_w) else fail_run($sformatf(
            "ERR @ %0t: wide rsp id %0d data %h err %b, expected id %0d data %h err %b",
            $time, wide_rsp.id, wide_rsp.data, wide_rsp.err,
            exp_w.id, exp_w.data, exp_w.err));
        end
        assert (!src_err) else fail_run("Joined port carried a source bit of the wrong port");
      end
    end
  end

  // Random response back-pressure on both requester ports
  initial begin : rsp_ready_proc
    forever begin
      @(posedge clk);
      #2ns;
      narrow_rsp_ready = rand_rsp_ready ? 1'($urandom_range(1)) : 1'b1;
      wide_rsp_ready   = rand_rsp_ready ? 1'($urandom_range(1)) : 1'b1;
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : main_proc
    narrow_req_t n;
    wide_req_t   w;
    int unsigned waited;
    void'($urandom(32'ha9785a28));
    narrow_req       = '0;
    narrow_req_valid = 1'b0;
    narrow_rsp_ready = 1'b1;
    wide_req         = '0;
    wide_req_valid   = 1'b0;
    wide_rsp_ready   = 1'b1;
    hold_rsp         = 1'b0;
    rand_rsp_ready   = 1'b0;
    waited           = 0;
    while (!rst_n) begin
      if (waited == Timeout) begin
        fail_run("Reset was never released");
      end
      @(posedge clk);
      waited++;
    end
    @(negedge clk);
    assert (!join_req_valid && !narrow_rsp_valid && !wide_rsp_valid) else fail_run(
      $sformatf("ERR @ %0t: a valid output is high after reset", $time));
    @(posedge clk);
    #2ns;

    // Full wide write, partial overwrite, then read back the line
    w = '{we: 1'b1, addr: 32'h100, id: 3'd2, data: {4{32'h0123_4567}}, strb: '1};
    send(SRC_WIDE, '0, w);
    w = '{we: 1'b1, addr: 32'h100, id: 3'd4, data: {4{32'hfedc_ba98}}, strb: 16'h0ff0};
    send(SRC_WIDE, '0, w);
    w.we = 1'b0;
    w.id = 3'd6;
    send(SRC_WIDE, '0, w);
    drain();

    // One narrow word per lane, seen through a wide read and narrow reads
    for (int lane = 0; lane < LaneCount; lane++) begin
      n = '{we: 1'b1, addr: 32'h200 + 4 * lane, id: 3'd1, data: 32'hc0de_0000 + lane, strb: '1};
      send(SRC_NARROW, n, '0);
    end
    w = '{we: 1'b0, addr: 32'h200, id: 3'd0, data: '0, strb: '0};
    send(SRC_WIDE, '0, w);
    for (int lane = 0; lane < LaneCount; lane++) begin
      n = '{we: 1'b0, addr: 32'h200 + 4 * lane, id: 3'd3, data: '0, strb: '0};
      send(SRC_NARROW, n, '0);
    end
    drain();

    // Fill the lane FIFO while the memory sits on its responses
    hold_rsp = 1'b1;
    for (int i = 0; i < NarrowMaxTxns; i++) begin
      n = '{we: 1'b0, addr: 32'h200 + 4 * (i % 4), id: 3'(2 * i + 1), data: '0, strb: '0};
      send(SRC_NARROW, n, '0);
    end
    n = '{we: 1'b0, addr: 32'h20c, id: 3'd7, data: '0, strb: '0};
    narrow_req       = n;
    narrow_req_valid = 1'b1;
    repeat (StallCycles) begin
      @(negedge clk);
      assert (!narrow_req_ready) else fail_run($sformatf(
        "ERR @ %0t: narrow port took more than %0d requests", $time, NarrowMaxTxns));
    end
    @(posedge clk);
    #2ns;
    hold_rsp = 1'b0;
    send(SRC_NARROW, n, '0);
    drain();

    // Mixed random traffic under back-pressure on every channel
    rand_rsp_ready = 1'b1;
    fork
      for (int i = 0; i < RandTxns; i++) begin
        send(SRC_NARROW, rand_narrow(), '0);
      end
      for (int i = 0; i < RandTxns; i++) begin
        send(SRC_WIDE, '0, rand_wide());
      end
    join
    drain();

    $display("** PASS **");
    $finish;
  end

endmodule

/* sim.f */
common/nw_join_pkg.sv
narrow_upsizer/narrow_upsizer.sv
join_mux/join_mux.sv
source/nw_join_top.sv
verif/tb_clk_gen.sv
verif/tb_mem_model.sv
verif/tb_nw_join.sv

/* Bender.yml */
package:
  name: nw_join

sources:
  # Shared package first, then the RTL blocks and the top level
  - common/nw_join_pkg.sv
  - narrow_upsizer/narrow_upsizer.sv
  - join_mux/join_mux.sv
  - source/nw_join_top.sv

  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_mem_model.sv
      - verif/tb_nw_join.sv
